//--- common/aib_rx_consts.svh
// Sizing constants for the receive datapath
//   AIB_DWIDTH       lane word width
//   AIB_FIFO_AWIDTH  FIFO address width, also threshold width
//   AIB_WA_RUN       marker run length needed for word lock
`ifndef AIB_RX_CONSTS_SVH
`define AIB_RX_CONSTS_SVH

// Lane word width in bits
`define AIB_DWIDTH 80

// Phase-comp FIFO address bits, 16 entries
`define AIB_FIFO_AWIDTH 4

// Consecutive marker words before the aligner locks
`define AIB_WA_RUN 4

`endif

//--- common/aib_rx_pkg.sv
// Shared types for the receive datapath
//   fifo_mode_e  FIFO mode encoding
//   aib_word_t   one lane word
`default_nettype none

`include "aib_rx_consts.svh"

package aib_rx_pkg;

   // **************************************************************************
   // FIFO mode, matches the r_fifo_mode CSR field
   // **************************************************************************
   typedef enum logic [1:0] {
      FIFO_1X = 2'd0,   // Full rate
      FIFO_2X = 2'd1,   // Reserved, runs as full rate
      FIFO_4X = 2'd2,   // Reserved, runs as full rate
      REG_MOD = 2'd3    // Register mode, FIFO off
   } fifo_mode_e;

   // One lane word as seen on fifo_din and fifo_dout
   typedef logic [`AIB_DWIDTH-1:0] aib_word_t;

endpackage : aib_rx_pkg

`default_nettype wire

//--- common/aib_fifo_thr_if.sv
// Threshold bundle for the phase-comp FIFO
//   cfg   side that sets the four thresholds
//   fifo  side that compares occupancy against them
`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_consts.svh"

interface aib_fifo_thr_if;

   logic [`AIB_FIFO_AWIDTH-1:0] r_empty;   // Empty at or below this
   logic [`AIB_FIFO_AWIDTH-1:0] r_pempty;  // Partially empty at or below
   logic [`AIB_FIFO_AWIDTH-1:0] r_pfull;   // Partially full at or above
   logic [`AIB_FIFO_AWIDTH-1:0] r_full;    // Full at or above

   // Config registers drive the levels
   modport cfg  (output r_empty, output r_pempty, output r_pfull, output r_full);

   // FIFO core only samples them
   modport fifo (input  r_empty, input  r_pempty, input  r_pfull, input  r_full);

endinterface : aib_fifo_thr_if

`default_nettype wire

//--- source/aib_bitsync.sv
// Two-flop level synchronizer
// Carries a slow level or gray code bit into the clk domain
`timescale 1ns/1ps
`default_nettype none

module aib_bitsync (
   input  logic clk,       // Destination clock
   input  logic rst_n,     // Sync reset, active low
   input  logic data_in,   // Level from the source domain
   output logic data_out   // Level in the clk domain
);

   logic meta_q;           // First stage, may go metastable

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         meta_q   <= 1'b0;
         data_out <= 1'b0;
      end else begin
         meta_q   <= data_in;  // Capture async level
         data_out <= meta_q;   // Settled copy
      end
   end

endmodule : aib_bitsync

`default_nettype wire

//--- source/aib_rx_word_align.sv
// Word aligner for the receive lane
// Counts consecutive words with the marker bit set and raises a
// sticky lock once the run reaches AIB_WA_RUN
`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_consts.svh"

module aib_rx_word_align
   import aib_rx_pkg::*;
(
   input  logic       wr_clk,     // Write domain clock
   input  logic       wr_rst_n,   // Write domain reset, active low
   input  aib_word_t  fifo_din,   // Incoming lane word
   input  logic [4:0] r_mkbit,    // Marker bit index
   output logic       wa_lock     // Sticky word lock
);

   // Counter wide enough to hold the full run
   localparam int CNT_W = $clog2(`AIB_WA_RUN + 1);

   logic [CNT_W-1:0] run_cnt;     // Consecutive marker hits
   logic             mk_hit;      // Marker bit set this word

   assign mk_hit = (fifo_din[r_mkbit] == 1'b1);

   // **************************************************************************
   // Run counter and lock
   // **************************************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         run_cnt <= '0;
         wa_lock <= 1'b0;
      end else begin
         if (!mk_hit) begin
            run_cnt <= '0;                         // Miss breaks the run
         end else if (run_cnt != CNT_W'(`AIB_WA_RUN)) begin
            run_cnt <= run_cnt + 1'b1;             // Saturates at full run
         end

         // Last hit of the run, lock from the next cycle on
         if (mk_hit && (run_cnt == CNT_W'(`AIB_WA_RUN - 1))) begin
            wa_lock <= 1'b1;
         end
      end
   end

endmodule : aib_rx_word_align

`default_nettype wire

//--- aib_adaptrxdp_fifo/aib_adaptrxdp_async_fifo.sv
// Dual-clock FIFO core for the phase-comp path
//   16-entry memory, binary and gray pointers per domain
//   gray pointers cross through aib_bitsync, one per bit
//   threshold flags from per-domain occupancy
`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_consts.svh"

module aib_adaptrxdp_async_fifo
   import aib_rx_pkg::*;
(
   input  logic         wr_clk,     // Write domain clock
   input  logic         wr_rst_n,   // Write domain reset, active low
   input  logic         wr_en,      // Push one word
   input  aib_word_t    wr_data,    // Word to push
   input  logic         rd_clk,     // Read domain clock
   input  logic         rd_rst_n,   // Read domain reset, active low
   input  logic         rd_en,      // Pop one word
   output aib_word_t    rd_data,    // Entry at read pointer
   aib_fifo_thr_if.fifo thr,        // Flag thresholds
   output logic         wr_full,    // Write occupancy >= r_full
   output logic         wr_pfull,   // Write occupancy >= r_pfull
   output logic         rd_empty,   // Read occupancy <= r_empty
   output logic         rd_pempty   // Read occupancy <= r_pempty
);

   localparam int AW    = `AIB_FIFO_AWIDTH;
   localparam int DEPTH = 1 << AW;

   aib_word_t   mem [0:DEPTH-1];   // Storage, no reset

   logic [AW:0] wptr_bin;          // Write pointer, extra wrap bit
   logic [AW:0] wptr_bin_nxt;
   logic [AW:0] wptr_gray;         // Registered gray copy for crossing
   logic [AW:0] wptr_gray_rd;      // Write gray in read domain
   logic [AW:0] wptr_bin_rd;

   logic [AW:0] rptr_bin;          // Read pointer, extra wrap bit
   logic [AW:0] rptr_bin_nxt;
   logic [AW:0] rptr_gray;
   logic [AW:0] rptr_gray_wr;      // Read gray in write domain
   logic [AW:0] rptr_bin_wr;

   logic [AW:0] wr_occ;            // Occupancy seen by writer
   logic [AW:0] rd_occ;            // Occupancy seen by reader

   function automatic logic [AW:0] bin2gray(input logic [AW:0] bin);
      return bin ^ (bin >> 1);
   endfunction

   function automatic logic [AW:0] gray2bin(input logic [AW:0] gray);
      logic [AW:0] bin;
      bin[AW] = gray[AW];
      for (int i = AW - 1; i >= 0; i--) begin
         bin[i] = bin[i + 1] ^ gray[i];  // Fold down from MSB
      end
      return bin;
   endfunction

   // **************************************************************************
   // Write domain
   // **************************************************************************
   assign wptr_bin_nxt = wptr_bin + 1'b1;

   always_ff @(posedge wr_clk) begin
      if (wr_en) begin
         mem[wptr_bin[AW-1:0]] <= wr_data;  // Drop wrap bit for address
      end
   end

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wptr_bin  <= '0;
         wptr_gray <= '0;
      end else if (wr_en) begin
         wptr_bin  <= wptr_bin_nxt;
         wptr_gray <= bin2gray(wptr_bin_nxt);  // One bit flips per push
      end
   end

   assign rptr_bin_wr = gray2bin(rptr_gray_wr);
   assign wr_occ      = wptr_bin - rptr_bin_wr;  // Wraps correctly mod 32

   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wr_full  <= 1'b0;
         wr_pfull <= 1'b0;
      end else begin
         wr_full  <= (wr_occ >= {1'b0, thr.r_full});
         wr_pfull <= (wr_occ >= {1'b0, thr.r_pfull});
      end
   end

   // **************************************************************************
   // Read domain
   // **************************************************************************
   assign rptr_bin_nxt = rptr_bin + 1'b1;
   assign rd_data      = mem[rptr_bin[AW-1:0]];  // Show-ahead read

   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rptr_bin  <= '0;
         rptr_gray <= '0;
      end else if (rd_en) begin
         rptr_bin  <= rptr_bin_nxt;
         rptr_gray <= bin2gray(rptr_bin_nxt);
      end
   end

   assign wptr_bin_rd = gray2bin(wptr_gray_rd);
   assign rd_occ      = wptr_bin_rd - rptr_bin;

   // Empty side comes out of reset asserted
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         rd_empty  <= 1'b1;
         rd_pempty <= 1'b1;
      end else begin
         rd_empty  <= (rd_occ <= {1'b0, thr.r_empty});
         rd_pempty <= (rd_occ <= {1'b0, thr.r_pempty});
      end
   end

   // **************************************************************************
   // Pointer crossing, one synchronizer per gray bit
   // **************************************************************************
   for (genvar g = 0; g <= AW; g++) begin : g_ptr_sync
      aib_bitsync u_wptr_sync (
         .clk      (rd_clk),
         .rst_n    (rd_rst_n),
         .data_in  (wptr_gray[g]),
         .data_out (wptr_gray_rd[g])
      );

      aib_bitsync u_rptr_sync (
         .clk      (wr_clk),
         .rst_n    (wr_rst_n),
         .data_in  (rptr_gray[g]),
         .data_out (rptr_gray_wr[g])
      );
   end

endmodule : aib_adaptrxdp_async_fifo

`default_nettype wire

//--- aib_adaptrxdp_fifo/aib_adaptrxdp_fifo.sv
// Phase-compensation wrapper around the async FIFO
//   mode decode, sticky and delayed write enable
//   write enable crossed to read domain with programmable tap
//   registered zero-filled read data and align_done
`timescale 1ns/1ps
`default_nettype none

module aib_adaptrxdp_fifo
   import aib_rx_pkg::*;
(
   input  logic         wr_clk,             // Write domain clock
   input  logic         wr_rst_n,           // Write domain reset, active low
   input  aib_word_t    fifo_din,           // Lane word in
   input  logic         rd_clk,             // Read domain clock
   input  logic         rd_rst_n,           // Read domain reset, active low
   aib_fifo_thr_if.fifo thr,                // Flag thresholds
   input  fifo_mode_e   r_fifo_mode,        // Phase-comp or register mode
   input  logic [3:0]   r_phcomp_rd_delay,  // Read start delay, 2 to 7
   input  logic         r_wa_en,            // Wait for word lock
   input  logic         wa_lock,            // Lock from the aligner
   output aib_word_t    fifo_dout,          // Registered read data
   output logic         fifo_empty,
   output logic         fifo_pempty,
   output logic         fifo_pfull,
   output logic         fifo_full,
   output logic         align_done          // Reading under way
);

   logic       phcomp_mode;   // FIFO in use
   logic       wren_d0;       // Sticky start
   logic       wren_d1;
   logic       wren_d2;       // Delayed write enable
   logic       wr_en;
   logic       wren_sync2;    // Write enable after 2-flop sync
   logic [7:3] wren_dly;      // Further read-domain stages
   logic       rden_tap;      // Selected delay stage
   logic       rd_en;
   aib_word_t  fifo_out;      // Raw entry at read pointer

   // **************************************************************************
   // Mode decode
   // **************************************************************************
   always_comb begin
      case (r_fifo_mode)
         FIFO_1X, FIFO_2X, FIFO_4X: phcomp_mode = 1'b1;  // All run at full rate
         REG_MOD:                   phcomp_mode = 1'b0;
         default:                   phcomp_mode = 1'b0;
      endcase
   end

   // **************************************************************************
   // Write enable, sticky start plus two stages
   // **************************************************************************
   always_ff @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         wren_d0 <= 1'b0;
         wren_d1 <= 1'b0;
         wren_d2 <= 1'b0;
      end else begin
         wren_d0 <= wren_d0 | ~r_wa_en | wa_lock;  // Holds once set
         wren_d1 <= wren_d0;
         wren_d2 <= wren_d1;
      end
   end

   assign wr_en = phcomp_mode & wren_d2;

   // Write enable into the read domain
   aib_bitsync u_wren_sync (
      .clk      (rd_clk),
      .rst_n    (rd_rst_n),
      .data_in  (wren_d2),
      .data_out (wren_sync2)
   );

   // **************************************************************************
   // Read enable, programmable pointer gap
   // **************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         wren_dly <= '0;
      end else begin
         wren_dly[3]   <= wren_sync2;
         wren_dly[7:4] <= wren_dly[6:3];  // Stages 4 to 7
      end
   end

   always_comb begin
      case (r_phcomp_rd_delay)
         4'd3:    rden_tap = wren_dly[3];
         4'd4:    rden_tap = wren_dly[4];
         4'd5:    rden_tap = wren_dly[5];
         4'd6:    rden_tap = wren_dly[6];
         4'd7:    rden_tap = wren_dly[7];
         default: rden_tap = wren_sync2;  // Shortest gap
      endcase
   end

   assign rd_en = phcomp_mode & rden_tap;

   aib_adaptrxdp_async_fifo u_async_fifo (
      .wr_clk    (wr_clk),
      .wr_rst_n  (wr_rst_n),
      .wr_en     (wr_en),
      .wr_data   (fifo_din),
      .rd_clk    (rd_clk),
      .rd_rst_n  (rd_rst_n),
      .rd_en     (rd_en),
      .rd_data   (fifo_out),
      .thr       (thr),
      .wr_full   (fifo_full),
      .wr_pfull  (fifo_pfull),
      .rd_empty  (fifo_empty),
      .rd_pempty (fifo_pempty)
   );

   // **************************************************************************
   // Output register
   // **************************************************************************
   always_ff @(posedge rd_clk) begin
      if (!rd_rst_n) begin
         fifo_dout  <= '0;
         align_done <= 1'b0;
      end else begin
         fifo_dout  <= rd_en ? fifo_out : '0;  // Zero when not reading
         align_done <= rd_en;
      end
   end

endmodule : aib_adaptrxdp_fifo

`default_nettype wire

//--- source/aib_rx_datapath_top.sv
// Receive datapath top level
//   word aligner in the write domain
//   phase-comp FIFO wrapper into the read domain
//   threshold bundle from the configuration ports
`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_consts.svh"

module aib_rx_datapath_top
   import aib_rx_pkg::*;
(
   input  logic                        wr_clk,             // Write domain clock
   input  logic                        wr_rst_n,           // Write reset, active low
   input  aib_word_t                   fifo_din,           // Lane word in
   input  logic                        rd_clk,             // Read domain clock
   input  logic                        rd_rst_n,           // Read reset, active low
   input  logic [`AIB_FIFO_AWIDTH-1:0] r_empty,
   input  logic [`AIB_FIFO_AWIDTH-1:0] r_pempty,
   input  logic [`AIB_FIFO_AWIDTH-1:0] r_pfull,
   input  logic [`AIB_FIFO_AWIDTH-1:0] r_full,
   input  fifo_mode_e                  r_fifo_mode,
   input  logic [3:0]                  r_phcomp_rd_delay,  // Read pointer gap
   input  logic                        r_wa_en,            // Word align enable
   input  logic [4:0]                  r_mkbit,            // Marker bit index
   output aib_word_t                   fifo_dout,
   output logic                        fifo_empty,
   output logic                        fifo_pempty,
   output logic                        fifo_pfull,
   output logic                        fifo_full,
   output logic                        align_done
);

   logic wa_lock;             // Aligner to wrapper, write domain

   aib_fifo_thr_if thr_if ();

   assign thr_if.r_empty  = r_empty;
   assign thr_if.r_pempty = r_pempty;
   assign thr_if.r_pfull  = r_pfull;
   assign thr_if.r_full   = r_full;

   aib_rx_word_align u_word_align (
      .wr_clk   (wr_clk),
      .wr_rst_n (wr_rst_n),
      .fifo_din (fifo_din),
      .r_mkbit  (r_mkbit),
      .wa_lock  (wa_lock)
   );

   aib_adaptrxdp_fifo u_rxdp_fifo (
      .wr_clk            (wr_clk),
      .wr_rst_n          (wr_rst_n),
      .fifo_din          (fifo_din),
      .rd_clk            (rd_clk),
      .rd_rst_n          (rd_rst_n),
      .thr               (thr_if),
      .r_fifo_mode       (r_fifo_mode),
      .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .r_wa_en           (r_wa_en),
      .wa_lock           (wa_lock),
      .fifo_dout         (fifo_dout),
      .fifo_empty        (fifo_empty),
      .fifo_pempty       (fifo_pempty),
      .fifo_pfull        (fifo_pfull),
      .fifo_full         (fifo_full),
      .align_done        (align_done)
   );

endmodule : aib_rx_datapath_top

`default_nettype wire

//--- tests/tb_aib_rx_datapath.sv
// Testbench for the receive datapath
//   reset state, in-order transfer at read delays 2 and 7
//   word align lock at two marker bits, register mode
//   stored-word model in the write domain, output monitor in the read domain
`timescale 1ns/1ps
`default_nettype none

`include "aib_rx_consts.svh"

module tb_aib_rx_datapath
   import aib_rx_pkg::*;
();

   logic                        wr_clk;
   logic                        wr_rst_n;
   aib_word_t                   fifo_din;
   logic                        rd_clk;
   logic                        rd_rst_n;
   logic [`AIB_FIFO_AWIDTH-1:0] r_empty;
   logic [`AIB_FIFO_AWIDTH-1:0] r_pempty;
   logic [`AIB_FIFO_AWIDTH-1:0] r_pfull;
   logic [`AIB_FIFO_AWIDTH-1:0] r_full;
   fifo_mode_e                  r_fifo_mode;
   logic [3:0]                  r_phcomp_rd_delay;
   logic                        r_wa_en;
   logic [4:0]                  r_mkbit;
   aib_word_t                   fifo_dout;
   logic                        fifo_empty;
   logic                        fifo_pempty;
   logic                        fifo_pfull;
   logic                        fifo_full;
   logic                        align_done;

   aib_word_t ref_q [$];        // Words expected at the output, in order
   aib_word_t exp_word;
   aib_word_t first_out;        // First nonzero output of a test
   string     test_name;
   logic      check_on;         // Monitor active
   int        n_pushed;
   int        n_out;
   int        steady_cnt;       // Read cycles with align_done high
   int        word_cnt;         // Payload counter, upper word bits
   int        hits;             // Model marker run
   logic      lock_seen;
   logic      armed;            // Model start bit
   int        arm_wait;

   aib_rx_datapath_top uut (
      .wr_clk (wr_clk), .wr_rst_n (wr_rst_n), .fifo_din (fifo_din),
      .rd_clk (rd_clk), .rd_rst_n (rd_rst_n),
      .r_empty (r_empty), .r_pempty (r_pempty), .r_pfull (r_pfull), .r_full (r_full),
      .r_fifo_mode (r_fifo_mode), .r_phcomp_rd_delay (r_phcomp_rd_delay),
      .r_wa_en (r_wa_en), .r_mkbit (r_mkbit),
      .fifo_dout (fifo_dout), .fifo_empty (fifo_empty), .fifo_pempty (fifo_pempty),
      .fifo_pfull (fifo_pfull), .fifo_full (fifo_full), .align_done (align_done)
   );

   initial begin
      rd_clk = 1'b0;
      forever #2 rd_clk = ~rd_clk;
   end

   initial begin
      wr_clk = 1'b0;
      #1;                                   // Write clock lags by 1 ns
      forever #2 wr_clk = ~wr_clk;
   end

   task automatic report_mismatch(input string name, input aib_word_t exp, input aib_word_t act);
      $display("TB FAILED");
      $display("Mismatch test=%s expected=%h actual=%h", name, exp, act);
      $fatal(1, "Value check failed");
   endtask

   task automatic report_failure(input string msg);
      $display("TB FAILED");
      $display("%s", msg);
      $fatal(1, "Check failed");
   endtask

   // Counter in the top bits keeps every word nonzero and unique
   function automatic aib_word_t make_word(input int cnt, input logic [31:0] low);
      return {32'(cnt), 16'h5a5a, low};
   endfunction

   // **************************************************************************
   // Write-domain model, stores from the third edge after the start bit
   // **************************************************************************
   always @(posedge wr_clk) begin
      if (!wr_rst_n) begin
         hits      = 0;
         lock_seen = 1'b0;
         armed     = 1'b0;
         arm_wait  = 0;
      end else begin
         if (armed) begin
            if (arm_wait == 0) begin
               if (r_fifo_mode != REG_MOD) begin
                  ref_q.push_back(fifo_din);
                  n_pushed++;
               end
            end else begin
               arm_wait--;
            end
         end else if (!r_wa_en || lock_seen) begin
            armed    = 1'b1;
            arm_wait = 2;                   // Two edges of delay
         end
         hits = fifo_din[r_mkbit] ? hits + 1 : 0;
         if (hits >= `AIB_WA_RUN) begin
            lock_seen = 1'b1;               // Seen from the next edge on
         end
      end
   end

   // **************************************************************************
   // Output monitor, samples on the read falling edge
   // **************************************************************************
   always @(negedge rd_clk) begin
      if (check_on) begin
         if (!align_done) begin
            assert (fifo_dout == '0)
               else report_mismatch({test_name, " idle output"}, '0, fifo_dout);
         end
         if (r_fifo_mode == REG_MOD) begin
            assert (!align_done)
               else report_failure({"align_done rose in register mode in ", test_name});
         end
         if (fifo_dout != '0) begin
            assert (ref_q.size() > 0)
               else report_failure({"Output word without a stored word in ", test_name});
            exp_word = ref_q.pop_front();
            assert (fifo_dout == exp_word) else report_mismatch(test_name, exp_word, fifo_dout);
            if (n_out == 0) begin
               first_out = fifo_dout;
            end
            n_out++;
         end
         steady_cnt = align_done ? steady_cnt + 1 : 0;
         if (steady_cnt > 8) begin
            assert (!fifo_full)
               else report_mismatch({test_name, " full"}, '0, aib_word_t'(fifo_full));
            assert (!fifo_pfull)
               else report_mismatch({test_name, " pfull"}, '0, aib_word_t'(fifo_pfull));
            if (r_phcomp_rd_delay == 4'd7) begin
               assert (!fifo_empty)
                  else report_mismatch({test_name, " empty"}, '0, aib_word_t'(fifo_empty));
               assert (!fifo_pempty)
                  else report_mismatch({test_name, " pempty"}, '0, aib_word_t'(fifo_pempty));
            end else begin
               // Reader starts as soon as the first word shows up
               assert (fifo_pempty)
                  else report_mismatch({test_name, " pempty"}, aib_word_t'(1),
                                       aib_word_t'(fifo_pempty));
            end
         end
      end
   end

   // Both resets low, config applied, reset state checked after release
   task automatic apply_reset(input string name, input fifo_mode_e mode,
                              input logic [3:0] delay, input logic wa_en,
                              input logic [4:0] mkbit);
      @(negedge wr_clk);
      check_on          = 1'b0;
      test_name         = name;
      wr_rst_n          = 1'b0;
      fifo_din          = make_word(word_cnt, 32'h0);  // Marker clear
      word_cnt++;
      r_fifo_mode       = mode;
      r_phcomp_rd_delay = delay;
      r_wa_en           = wa_en;
      r_mkbit           = mkbit;
      @(negedge rd_clk);
      rd_rst_n = 1'b0;
      repeat (2) @(negedge rd_clk);
      ref_q.delete();
      n_pushed   = 0;
      n_out      = 0;
      steady_cnt = 0;
      @(negedge wr_clk);
      wr_rst_n = 1'b1;
      check_on = 1'b1;
      @(negedge rd_clk);
      rd_rst_n = 1'b1;
      @(negedge rd_clk);
      assert (fifo_dout == '0) else report_mismatch({name, " reset dout"}, '0, fifo_dout);
      assert (!align_done)
         else report_mismatch({name, " reset align_done"}, '0, aib_word_t'(align_done));
      assert (!fifo_full)
         else report_mismatch({name, " reset full"}, '0, aib_word_t'(fifo_full));
      assert (!fifo_pfull)
         else report_mismatch({name, " reset pfull"}, '0, aib_word_t'(fifo_pfull));
      assert (fifo_empty)
         else report_mismatch({name, " reset empty"}, aib_word_t'(1), aib_word_t'(fifo_empty));
      assert (fifo_pempty)
         else report_mismatch({name, " reset pempty"}, aib_word_t'(1), aib_word_t'(fifo_pempty));
   endtask

   task automatic drive_count_words(input int n);
      for (int i = 0; i < n; i++) begin
         @(negedge wr_clk);
         fifo_din = make_word(word_cnt, 32'(word_cnt));
         word_cnt++;
      end
   endtask

   // Random words, marker run never reaches lock length
   task automatic drive_marker_noise(input int n);
      int          run;
      logic [31:0] low;
      run = 0;
      for (int i = 0; i < n; i++) begin
         low = $urandom;
         if (run == `AIB_WA_RUN - 1) begin
            low[r_mkbit] = 1'b0;
         end
         run = low[r_mkbit] ? run + 1 : 0;
         @(negedge wr_clk);
         fifo_din = make_word(word_cnt, low);
         word_cnt++;
      end
   endtask

   // One miss, the marker run, then four more words
   task automatic drive_marker_run(output aib_word_t lock_word);
      logic [31:0] low;
      for (int i = 0; i <= `AIB_WA_RUN + 4; i++) begin
         low          = 32'(word_cnt);
         low[r_mkbit] = (i >= 1) && (i <= `AIB_WA_RUN);
         @(negedge wr_clk);
         fifo_din = make_word(word_cnt, low);
         word_cnt++;
         if (i == `AIB_WA_RUN + 4) begin
            lock_word = fifo_din;           // 4 cycles after last marker
         end
      end
   endtask

   task automatic wait_for_outputs(input int target);
      int cycles;
      cycles = 0;
      while (n_out < target) begin
         @(negedge rd_clk);
         cycles++;
         if (cycles > 200) begin
            report_failure({"Timeout waiting for output words in ", test_name});
         end
      end
   endtask

   task automatic run_plain_transfer(input string name, input logic [3:0] delay);
      apply_reset(name, FIFO_1X, delay, 1'b0, 5'd0);
      drive_count_words(40);
      wait_for_outputs(n_pushed);
   endtask

   task automatic run_word_align(input string name, input logic [4:0] mkbit);
      aib_word_t lock_word;
      apply_reset(name, FIFO_1X, 4'd7, 1'b1, mkbit);
      drive_marker_noise(40);
      assert (n_pushed == 0 && !align_done)
         else report_failure({"Write started before word lock in ", name});
      drive_marker_run(lock_word);
      drive_count_words(20);
      wait_for_outputs(n_pushed);
      assert (first_out == lock_word) else report_mismatch(name, lock_word, first_out);
   endtask

   task automatic run_register_mode();
      apply_reset("reg_mode", REG_MOD, 4'd2, 1'b0, 5'd0);
      drive_count_words(40);
      repeat (20) @(negedge rd_clk);
      assert (fifo_empty && fifo_pempty)
         else report_failure("FIFO was written in register mode");
   endtask

   // **************************************************************************
   // Test sequence
   // **************************************************************************
   initial begin
      void'($urandom(32'hdb9c));
      wr_rst_n          = 1'b0;
      rd_rst_n          = 1'b0;
      fifo_din          = '0;
      r_empty           = 4'd0;
      r_pempty          = 4'd2;
      r_pfull           = 4'd12;
      r_full            = 4'd15;
      r_fifo_mode       = FIFO_1X;
      r_phcomp_rd_delay = 4'd2;
      r_wa_en           = 1'b0;
      r_mkbit           = 5'd0;
      check_on          = 1'b0;
      word_cnt          = 1;
      n_pushed          = 0;
      n_out             = 0;
      steady_cnt        = 0;
      first_out         = '0;
      run_plain_transfer("plain_delay2", 4'd2);
      run_plain_transfer("plain_delay7", 4'd7);
      run_word_align("align_mkbit5", 5'd5);
      run_word_align("align_mkbit31", 5'd31);
      run_register_mode();
      $display("TB PASSED");
      $finish;
   end

endmodule : tb_aib_rx_datapath

`default_nettype wire

//--- aib_rx_datapath.f
+incdir+common
common/aib_rx_pkg.sv
common/aib_fifo_thr_if.sv
source/aib_bitsync.sv
source/aib_rx_word_align.sv
aib_adaptrxdp_fifo/aib_adaptrxdp_async_fifo.sv
aib_adaptrxdp_fifo/aib_adaptrxdp_fifo.sv
source/aib_rx_datapath_top.sv
tests/tb_aib_rx_datapath.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the receive datapath testbench with Verilator
rm -f sim.log build.log
verilator --binary --timing --assert -Wno-fatal -f aib_rx_datapath.f \
   --top-module tb_aib_rx_datapath -Mdir obj_dir > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/Vtb_aib_rx_datapath > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "TB PASSED" sim.log || { echo "Simulation did not pass"; exit 1; }
exit 0
